// File: design/csa_params.svh
`ifndef CSA_PARAMS_SVH
`define CSA_PARAMS_SVH

// datapath widths
`define CSA_SEED_W      48
`define CSA_CW_W        64
`define CSA_BLOCK_W     32
`define CSA_ROUND_W     16

// entries per fifo, power of two
`define CSA_FIFO_DEPTH  4

// register map, word addresses
`define CSA_ADDR_SEED_LO   4'd0
`define CSA_ADDR_SEED_HI   4'd1
`define CSA_ADDR_BLOCK     4'd2
`define CSA_ADDR_WINDOW    4'd3
`define CSA_ADDR_PUSH      4'd4
`define CSA_ADDR_STATUS    4'd5
`define CSA_ADDR_OUT_LO    4'd6
`define CSA_ADDR_OUT_HI    4'd7
`define CSA_ADDR_CW_LO     4'd8
`define CSA_ADDR_CW_HI     4'd9
`define CSA_ADDR_RES_BLOCK 4'd10
`define CSA_ADDR_RES_POP   4'd11

`endif

// File: design/csa_pkg.sv
`include "csa_params.svh"

package csa_pkg;

	// one queued search job
	typedef struct packed {
		logic [`CSA_BLOCK_W-1:0] block;
		logic [`CSA_SEED_W-1:0]  seed;
		// first round index
		logic [`CSA_ROUND_W-1:0] times_start;
		// round limit, exclusive
		logic [`CSA_ROUND_W-1:0] times;
	} csa_job_t;

	// tagged result of one job
	typedef struct packed {
		logic [`CSA_BLOCK_W-1:0] block;
		// lets the host match a result to its job
		logic [15:0]             seed_lo16;
		logic [`CSA_CW_W-1:0]    cw;
		logic [`CSA_CW_W-1:0]    out;
	} csa_result_t;

	// wishbone classic master signals
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		// word address
		logic [3:0]  adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

endpackage

// File: design/csa_sync_fifo.sv
`timescale 1ns/100ps
`include "csa_params.svh"

module csa_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `CSA_FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push_i,
	input  payload_t   push_data_i,
	input  logic       pop_i,
	output payload_t   pop_data_o,
	output logic       empty_o,
	output logic       full_o,
	output logic [3:0] level_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH) + 1;

	payload_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// requests at the wrong end are dropped
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head is always on the output
	assign pop_data_o = mem[rd_ptr];
	assign empty_o    = (count == '0);
	assign full_o     = (count == CW'(DEPTH));
	assign level_o    = 4'(count);

endmodule

// File: design/csa_calc_logic.sv
`timescale 1ns/100ps
`include "csa_params.svh"

module csa_calc_logic import csa_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        fifo_ready_i,
	output logic        fifo_ren_o,
	input  csa_job_t    job_i,
	output logic        calc_valid_o,
	input  logic        calc_ready_i,
	output csa_result_t result_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_HOLD
	} state_t;

	state_t                  state_q;
	// first cycle of run loads cw and state
	logic                    load_q;
	csa_job_t                job_q;
	logic [`CSA_ROUND_W-1:0] round_q;
	logic [`CSA_CW_W-1:0]    cw_q;
	logic [`CSA_CW_W-1:0]    mix_q;
	logic [`CSA_CW_W-1:0]    cw_next;
	logic                    rounds_done;

	// s0 s1 s2 c1 s3 s4 s5 c2, lowest byte first
	function automatic logic [`CSA_CW_W-1:0] expand_cw(
		input logic [`CSA_SEED_W-1:0] seed
	);
		logic [7:0] c1;
		logic [7:0] c2;
		c1 = seed[7:0] + seed[15:8] + seed[23:16];
		c2 = seed[31:24] + seed[39:32] + seed[47:40];
		return {c2, seed[47:24], c1, seed[23:0]};
	endfunction

	// stand-in for the real cipher rounds
	function automatic logic [`CSA_CW_W-1:0] mix_round(
		input logic [`CSA_CW_W-1:0]    st,
		input logic [`CSA_CW_W-1:0]    cw,
		input logic [`CSA_ROUND_W-1:0] r
	);
		logic [`CSA_CW_W-1:0] rot;
		rot = (st << 13) | (st >> (`CSA_CW_W - 13));
		return rot ^ cw ^ {{(`CSA_CW_W - `CSA_ROUND_W){1'b0}}, r};
	endfunction

	assign cw_next     = expand_cw(job_q.seed);
	assign rounds_done = (round_q >= job_q.times);

	// take the head job straight from the fifo
	assign fifo_ren_o   = (state_q == ST_IDLE) && fifo_ready_i;
	assign calc_valid_o = (state_q == ST_HOLD);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			load_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (fifo_ready_i) begin
						state_q <= ST_RUN;
						load_q  <= 1'b1;
					end
				end
				ST_RUN: begin
					load_q <= 1'b0;
					if (!load_q && rounds_done)
						state_q <= ST_HOLD;
				end
				ST_HOLD: begin
					// result fifo takes it this cycle
					if (calc_ready_i)
						state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_ren_o) begin
			job_q   <= job_i;
			round_q <= job_i.times_start;
		end else if (state_q == ST_RUN) begin
			if (load_q) begin
				cw_q  <= cw_next;
				mix_q <= cw_next ^ {job_q.block, job_q.block};
			end else if (!rounds_done) begin
				mix_q   <= mix_round(mix_q, cw_q, round_q);
				round_q <= round_q + 1'b1;
			end
		end
	end

	// held steady through hold
	assign result_o = '{
		block:     job_q.block,
		seed_lo16: job_q.seed[15:0],
		cw:        cw_q,
		out:       mix_q
	};

endmodule

// File: design/csa_wb_regs.sv
`timescale 1ns/100ps
`include "csa_params.svh"

module csa_wb_regs import csa_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  wb_req_t     wb_req_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,
	output logic        job_push_o,
	output csa_job_t    job_o,
	input  logic        job_full_i,
	input  csa_result_t res_head_i,
	input  logic        res_empty_i,
	input  logic [3:0]  res_level_i,
	output logic        res_pop_o
);

	csa_job_t    job_q;
	logic [31:0] rd_word;
	logic [31:0] wr_mask;
	logic [31:0] wr_word;
	logic        access;
	logic        stall;
	logic        ack_set;
	logic        push_q;
	logic        pop_q;

	// new access only while no ack is out
	assign access  = wb_req_i.cyc && wb_req_i.stb && !wb_ack_o;
	// push into a full job fifo waits for a free slot
	assign stall   = wb_req_i.we && (wb_req_i.adr == `CSA_ADDR_PUSH) && job_full_i;
	assign ack_set = access && !stall;

	always_comb begin
		rd_word = '0;
		case (wb_req_i.adr)
			`CSA_ADDR_SEED_LO:   rd_word = job_q.seed[31:0];
			`CSA_ADDR_SEED_HI:   rd_word = {16'b0, job_q.seed[47:32]};
			`CSA_ADDR_BLOCK:     rd_word = job_q.block;
			`CSA_ADDR_WINDOW:    rd_word = {job_q.times_start, job_q.times};
			`CSA_ADDR_STATUS: begin
				rd_word = {24'b0, res_level_i, 2'b00, job_full_i, !res_empty_i};
			end
			`CSA_ADDR_OUT_LO:    if (!res_empty_i) rd_word = res_head_i.out[31:0];
			`CSA_ADDR_OUT_HI:    if (!res_empty_i) rd_word = res_head_i.out[63:32];
			`CSA_ADDR_CW_LO:     if (!res_empty_i) rd_word = res_head_i.cw[31:0];
			`CSA_ADDR_CW_HI:     if (!res_empty_i) rd_word = res_head_i.cw[63:32];
			`CSA_ADDR_RES_BLOCK: if (!res_empty_i) rd_word = res_head_i.block;
			`CSA_ADDR_RES_POP: begin
				if (!res_empty_i)
					rd_word = {16'b0, res_head_i.seed_lo16};
			end
			default:             rd_word = '0;
		endcase
	end

	// byte lanes merge into the current register value
	assign wr_mask = {{8{wb_req_i.sel[3]}}, {8{wb_req_i.sel[2]}},
			{8{wb_req_i.sel[1]}}, {8{wb_req_i.sel[0]}}};
	assign wr_word = (rd_word & ~wr_mask) | (wb_req_i.dat & wr_mask);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack_o <= 1'b0;
			push_q   <= 1'b0;
			pop_q    <= 1'b0;
			job_q    <= '0;
		end else begin
			wb_ack_o <= ack_set;
			push_q   <= ack_set && wb_req_i.we && (wb_req_i.adr == `CSA_ADDR_PUSH);
			// pop only what was actually read out
			pop_q    <= ack_set && !wb_req_i.we && !res_empty_i &&
					(wb_req_i.adr == `CSA_ADDR_RES_POP);
			if (ack_set && wb_req_i.we) begin
				case (wb_req_i.adr)
					`CSA_ADDR_SEED_LO: job_q.seed[31:0]  <= wr_word;
					`CSA_ADDR_SEED_HI: job_q.seed[47:32] <= wr_word[15:0];
					`CSA_ADDR_BLOCK:   job_q.block       <= wr_word;
					`CSA_ADDR_WINDOW: begin
						job_q.times_start <= wr_word[31:16];
						job_q.times       <= wr_word[15:0];
					end
					default: begin
						job_q <= job_q;
					end
				endcase
			end
		end
	end

	// read data lands with ack
	always_ff @(posedge clk) begin
		if (ack_set)
			wb_dat_o <= rd_word;
	end

	// both strobes sit in the ack cycle
	assign job_push_o = push_q && !job_full_i;
	assign res_pop_o  = pop_q;
	assign job_o      = job_q;

endmodule

// File: design/csa_search_top.sv
`timescale 1ns/100ps

module csa_search_top import csa_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  wb_req_t     wb_req_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o
);

	logic        job_push;
	csa_job_t    job_in;
	csa_job_t    job_head;
	logic        job_empty;
	logic        job_full;
	logic        fifo_ready;
	logic        fifo_ren;

	csa_result_t calc_result;
	logic        calc_valid;
	logic        calc_ready;
	csa_result_t res_head;
	logic        res_empty;
	logic        res_full;
	logic [3:0]  res_level;
	logic        res_pop;

	assign fifo_ready = !job_empty;
	assign calc_ready = !res_full;

	csa_wb_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_req_i    (wb_req_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.job_push_o  (job_push),
		.job_o       (job_in),
		.job_full_i  (job_full),
		.res_head_i  (res_head),
		.res_empty_i (res_empty),
		.res_level_i (res_level),
		.res_pop_o   (res_pop)
	);

	csa_sync_fifo #(.payload_t(csa_job_t)) u_job_fifo (
		.clk(clk), .rst_n(rst_n),
		.push_i(job_push), .push_data_i(job_in),
		.pop_i(fifo_ren), .pop_data_o(job_head),
		.empty_o(job_empty), .full_o(job_full), .level_o()
	);

	csa_calc_logic u_calc (
		.clk(clk), .rst_n(rst_n),
		.fifo_ready_i(fifo_ready), .fifo_ren_o(fifo_ren), .job_i(job_head),
		.calc_valid_o(calc_valid), .calc_ready_i(calc_ready), .result_o(calc_result)
	);

	// a push while full is dropped and the core holds its result
	csa_sync_fifo #(.payload_t(csa_result_t)) u_res_fifo (
		.clk(clk), .rst_n(rst_n),
		.push_i(calc_valid), .push_data_i(calc_result),
		.pop_i(res_pop), .pop_data_o(res_head),
		.empty_o(res_empty), .full_o(res_full), .level_o(res_level)
	);

endmodule

// File: bench/csa_search_tb.sv
`timescale 1ns/100ps
`include "csa_params.svh"

module csa_search_tb import csa_pkg::*; ();

	localparam int ACK_LIMIT  = 1000;
	localparam int POLL_LIMIT = 500;

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;

	logic [31:0] rng_state;
	int          error_count;
	int          check_count;
	int          test_errors_base;
	int          test_checks_base;
	string       test_name;
	csa_result_t expect_q[$];

	csa_search_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req_i (wb_req),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic logic [47:0] rand_seed();
		logic [31:0] lo;
		logic [31:0] hi;
		lo = xorshift32();
		hi = xorshift32();
		return {hi[15:0], lo};
	endfunction

	// reference model of checksum expansion and rotate/xor rounds
	function automatic csa_result_t predict(input logic [47:0] seed, input logic [31:0] block,
			input logic [15:0] ts, input logic [15:0] t);
		csa_result_t res;
		logic [7:0]  b [8];
		logic [63:0] cw;
		logic [63:0] st;
		int          r;
		b[0] = seed[7:0];
		b[1] = seed[15:8];
		b[2] = seed[23:16];
		b[3] = b[0] + b[1] + b[2];
		b[4] = seed[31:24];
		b[5] = seed[39:32];
		b[6] = seed[47:40];
		b[7] = b[4] + b[5] + b[6];
		cw = {b[7], b[6], b[5], b[4], b[3], b[2], b[1], b[0]};
		st = cw ^ {block, block};
		for (r = int'(ts); r < int'(t); r++)
			st = {st[50:0], st[63:51]} ^ cw ^ {48'h0, r[15:0]};
		res.block     = block;
		res.seed_lo16 = seed[15:0];
		res.cw        = cw;
		res.out       = st;
		return res;
	endfunction

	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("ERROR %0t ns: %s expected %h got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// one classic cycle with the request held until ack and dropped a cycle later
	task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		wb_req_t req;
		int      waited;
		req     = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		req.sel = 4'hf;
		waited  = 0;
		rdat    = '0;
		@(posedge clk);
		wb_req <= req;
		@(negedge clk);
		while (!wb_ack_o && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack_o) begin
			abort_run($sformatf("no bus ack from address %0d after %0d cycles", adr, waited));
		end else begin
			rdat = wb_dat_o;
			@(posedge clk);
			wb_req <= '0;
		end
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
		logic [31:0] dummy;
		wb_cycle(1'b1, adr, wdat, dummy);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
		wb_cycle(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic wait_result();
		logic [31:0] status;
		int          polls;
		polls = 0;
		wb_read(`CSA_ADDR_STATUS, status);
		while (!status[0] && polls < POLL_LIMIT) begin
			wb_read(`CSA_ADDR_STATUS, status);
			polls++;
		end
		if (!status[0])
			abort_run("no result became available within the poll limit");
	endtask

	task automatic submit_job(input logic [47:0] seed, input logic [31:0] block,
			input logic [15:0] ts, input logic [15:0] t);
		wb_write(`CSA_ADDR_SEED_LO, seed[31:0]);
		wb_write(`CSA_ADDR_SEED_HI, {16'h0, seed[47:32]});
		wb_write(`CSA_ADDR_BLOCK, block);
		wb_write(`CSA_ADDR_WINDOW, {ts, t});
		wb_write(`CSA_ADDR_PUSH, xorshift32());
		expect_q.push_back(predict(seed, block, ts, t));
	endtask

	// reads the head result word by word and pops it with the last read
	task automatic fetch_and_check();
		csa_result_t exp;
		logic [31:0] lo;
		logic [31:0] hi;
		exp = expect_q.pop_front();
		wb_read(`CSA_ADDR_OUT_LO, lo);
		wb_read(`CSA_ADDR_OUT_HI, hi);
		check_value("out", exp.out, {hi, lo});
		wb_read(`CSA_ADDR_CW_LO, lo);
		wb_read(`CSA_ADDR_CW_HI, hi);
		check_value("cw", exp.cw, {hi, lo});
		wb_read(`CSA_ADDR_RES_BLOCK, lo);
		check_value("block", 64'(exp.block), 64'(lo));
		wb_read(`CSA_ADDR_RES_POP, lo);
		check_value("seed_lo16", 64'(exp.seed_lo16), 64'(lo));
	endtask

	task automatic start_test(input string name);
		test_name        = name;
		test_errors_base = error_count;
		test_checks_base = check_count;
	endtask

	task automatic finish_test();
		$display("test %s: %0d checks, %0d errors", test_name,
			check_count - test_checks_base, error_count - test_errors_base);
	endtask

	task automatic run_random_job(input int max_len);
		logic [15:0] ts;
		logic [31:0] len;
		ts  = xorshift32() & 32'h7fff;
		len = xorshift32() % (max_len + 1);
		submit_job(rand_seed(), xorshift32(), ts, ts + len[15:0]);
		wait_result();
		fetch_and_check();
	endtask

	task automatic test_reset_and_regs();
		logic [31:0] word;
		logic [31:0] wdat;
		int          i;
		start_test("reset_and_regs");
		wb_read(`CSA_ADDR_STATUS, word);
		check_value("status", 64'h0, 64'(word));
		for (i = 0; i < 4; i++) begin
			wdat = xorshift32();
			wb_write(4'(i), wdat);
			wb_read(4'(i), word);
			if (i == 1)
				wdat = {16'h0, wdat[15:0]};
			check_value($sformatf("reg[%0d]", i), 64'(wdat), 64'(word));
		end
		for (i = 6; i < 12; i++) begin
			wb_read(4'(i), word);
			check_value($sformatf("reg[%0d]", i), 64'h0, 64'(word));
		end
		wb_read(`CSA_ADDR_STATUS, word);
		check_value("status", 64'h0, 64'(word));
		finish_test();
	endtask

	task automatic test_empty_window();
		logic [15:0] ts;
		logic [31:0] back;
		int          i;
		start_test("empty_window");
		for (i = 0; i < 4; i++) begin
			ts   = (xorshift32() & 32'h7fff) + 16'd8;
			back = xorshift32() % 8;
			submit_job(rand_seed(), xorshift32(), ts, (i == 0) ? 16'h0 : ts - back[15:0]);
			wait_result();
			fetch_and_check();
		end
		finish_test();
	endtask

	task automatic test_back_pressure();
		logic [31:0] word;
		logic [31:0] len;
		logic [15:0] ts;
		logic        full_seen;
		int          i;
		start_test("back_pressure");
		full_seen = 1'b0;
		for (i = 0; i < 9; i++) begin
			ts  = xorshift32() & 32'h3fff;
			len = 100 + xorshift32() % 64;
			submit_job(rand_seed(), xorshift32(), ts, ts + len[15:0]);
			wb_read(`CSA_ADDR_STATUS, word);
			full_seen |= word[1];
		end
		// nine jobs fill the job fifo, the core and the result fifo
		check_value("status", {56'h0, 4'(`CSA_FIFO_DEPTH), 4'b0011}, 64'(word));
		check_count++;
		assert (full_seen) else begin
			$display("the job FIFO full flag was never set while nine jobs were queued");
			error_count++;
		end
		for (i = 0; i < 9; i++) begin
			wait_result();
			fetch_and_check();
		end
		wb_read(`CSA_ADDR_STATUS, word);
		check_value("status.avail", 64'h0, 64'(word[0]));
		check_value("status.pending", 64'h0, 64'(word[7:4]));
		finish_test();
	endtask

	initial begin
		int i;
		rng_state   = 32'h7ef3_0282;
		error_count = 0;
		check_count = 0;
		rst_n       = 1'b0;
		wb_req      = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_and_regs();

		start_test("single_job");
		run_random_job(20);
		finish_test();

		test_empty_window();

		start_test("ordered_stream");
		for (i = 0; i < 40; i++)
			run_random_job(31);
		finish_test();

		test_back_pressure();

		$display("summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+design
design/csa_pkg.sv
design/csa_sync_fifo.sv
design/csa_calc_logic.sv
design/csa_wb_regs.sv
design/csa_search_top.sv
bench/csa_search_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module csa_search_tb -f tb.f -o csa_search_sim

./obj_dir/csa_search_sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
